//--- design/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// machine word width
`define DATA_WIDTH 32

// general purpose registers
`define REG_COUNT 32

// bits needed to name one register
`define REG_ADDR_WIDTH 5

`endif

//--- design/mipsPkg.sv
`include "decode_settings.svh"

package mipsPkg;

	// one machine word
	typedef logic [`DATA_WIDTH-1:0] wordT;

	// register number, rs rt rd fields
	typedef logic [`REG_ADDR_WIDTH-1:0] regAddrT;

	// decoded operation
	// anything outside the subset lands on RESERVED
	typedef enum logic [4:0] {
		ADDU,
		SUBU,
		AND,
		OR,
		XOR,
		NOR,
		SLT,
		SLTU,
		SLL,
		SRL,
		SRA,
		JR,
		ADDIU,
		ANDI,
		ORI,
		XORI,
		LUI,
		SLTI,
		SLTIU,
		LW,
		SW,
		BEQ,
		BNE,
		J,
		JAL,
		RESERVED
	} opT;

	// control bits carried down the pipe
	typedef struct packed {
		// result goes back to destReg
		logic regWrite;
		logic memRead;
		logic memWrite;
		// second alu operand is extendedImm
		logic aluSrcImm;
		// logical immediates are zero extended
		logic zeroExt;
		logic branch;
		logic jump;
		// jump target comes from srcA
		logic jumpReg;
		// write pcPlus4 + 4 into r31
		logic link;
	} ctlT;

	// what fetch hands to decode
	typedef struct packed {
		wordT pcPlus4;
		wordT instr;
		// fetch side fault, passed along untouched
		logic exceptionInstr;
	} fetchDataT;

	// decoded instruction, no operand values yet
	typedef struct packed {
		opT op;
		ctlT ctl;
		regAddrT srcRegA;
		regAddrT srcRegB;
		regAddrT destReg;
		logic [4:0] shamt;
		wordT extendedImm;
		wordT pcBranch;
		wordT pcJump;
		wordT pcPlus4;
		// reserved instruction
		logic exceptionRi;
		logic exceptionInstr;
	} decodeDataT;

	// ID/EX payload, decode result plus both operands
	typedef struct packed {
		decodeDataT decoded;
		wordT srcA;
		wordT srcB;
	} issueDataT;

	// register file write port
	typedef struct packed {
		logic en;
		regAddrT addr;
		wordT data;
	} regWriteT;

endpackage

//--- design/pipeReg.sv
module pipeReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input payloadT inData,
	output logic inReady,
	output logic outValid,
	output payloadT outData,
	input logic outReady
);

	logic full;
	payloadT held;

	// take a new entry when empty or when the old one leaves this cycle
	assign inReady = !full || outReady;
	assign outValid = full;
	assign outData = held;

	always_ff @(posedge clk) begin
		if (reset) begin
			full <= 1'b0;
		end else if (inValid && inReady) begin
			// load wins over drain
			full <= 1'b1;
		end else if (outReady) begin
			full <= 1'b0;
		end
	end

	// payload only, no reset needed
	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			held <= inData;
		end
	end

endmodule

//--- design/mainDecode.sv
`include "decode_settings.svh"

module mainDecode import mipsPkg::*; (
	input wordT instr,
	output opT op,
	output ctlT ctl,
	output regAddrT srcRegA,
	output regAddrT srcRegB,
	output regAddrT destReg,
	output logic reserved
);

	// primary opcodes
	localparam logic [5:0] opcSpecial = 6'b000000;
	localparam logic [5:0] opcJ = 6'b000010;
	localparam logic [5:0] opcJal = 6'b000011;
	localparam logic [5:0] opcBeq = 6'b000100;
	localparam logic [5:0] opcBne = 6'b000101;
	localparam logic [5:0] opcAddiu = 6'b001001;
	localparam logic [5:0] opcSlti = 6'b001010;
	localparam logic [5:0] opcSltiu = 6'b001011;
	localparam logic [5:0] opcAndi = 6'b001100;
	localparam logic [5:0] opcOri = 6'b001101;
	localparam logic [5:0] opcXori = 6'b001110;
	localparam logic [5:0] opcLui = 6'b001111;
	localparam logic [5:0] opcLw = 6'b100011;
	localparam logic [5:0] opcSw = 6'b101011;

	// function field, only under opcSpecial
	localparam logic [5:0] fnSll = 6'b000000;
	localparam logic [5:0] fnSrl = 6'b000010;
	localparam logic [5:0] fnSra = 6'b000011;
	localparam logic [5:0] fnJr = 6'b001000;
	localparam logic [5:0] fnAddu = 6'b100001;
	localparam logic [5:0] fnSubu = 6'b100011;
	localparam logic [5:0] fnAnd = 6'b100100;
	localparam logic [5:0] fnOr = 6'b100101;
	localparam logic [5:0] fnXor = 6'b100110;
	localparam logic [5:0] fnNor = 6'b100111;
	localparam logic [5:0] fnSlt = 6'b101010;
	localparam logic [5:0] fnSltu = 6'b101011;

	logic [5:0] opcode;
	logic [5:0] funct;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	// sources are always the rs and rt fields
	// unused ones are simply ignored further down the pipe
	assign srcRegA = rs;
	assign srcRegB = rt;

	// opcode and function field to operation
	always_comb begin
		op = RESERVED;
		case (opcode)
			opcSpecial: begin
				case (funct)
					fnSll: op = SLL;
					fnSrl: op = SRL;
					fnSra: op = SRA;
					fnJr: op = JR;
					fnAddu: op = ADDU;
					fnSubu: op = SUBU;
					fnAnd: op = AND;
					fnOr: op = OR;
					fnXor: op = XOR;
					fnNor: op = NOR;
					fnSlt: op = SLT;
					fnSltu: op = SLTU;
					default: op = RESERVED;
				endcase
			end
			opcJ: op = J;
			opcJal: op = JAL;
			opcBeq: op = BEQ;
			opcBne: op = BNE;
			opcAddiu: op = ADDIU;
			opcSlti: op = SLTI;
			opcSltiu: op = SLTIU;
			opcAndi: op = ANDI;
			opcOri: op = ORI;
			opcXori: op = XORI;
			opcLui: op = LUI;
			opcLw: op = LW;
			opcSw: op = SW;
			default: op = RESERVED;
		endcase
	end

	// control bits and destination from the operation
	always_comb begin
		ctl = '0;
		destReg = '0;
		case (op)
			ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA: begin
				ctl.regWrite = 1'b1;
				destReg = rd;
			end
			JR: begin
				ctl.jump = 1'b1;
				ctl.jumpReg = 1'b1;
			end
			ADDIU, SLTI, SLTIU, LUI: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				destReg = rt;
			end
			ANDI, ORI, XORI: begin
				ctl.regWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
				ctl.zeroExt = 1'b1;
				destReg = rt;
			end
			LW: begin
				ctl.regWrite = 1'b1;
				ctl.memRead = 1'b1;
				ctl.aluSrcImm = 1'b1;
				destReg = rt;
			end
			SW: begin
				ctl.memWrite = 1'b1;
				ctl.aluSrcImm = 1'b1;
			end
			BEQ, BNE: begin
				ctl.branch = 1'b1;
			end
			J: begin
				ctl.jump = 1'b1;
			end
			JAL: begin
				ctl.jump = 1'b1;
				ctl.link = 1'b1;
				ctl.regWrite = 1'b1;
				// link register is the last one
				destReg = regAddrT'(`REG_COUNT - 1);
			end
			default: begin
				// reserved, everything stays low
				ctl = '0;
			end
		endcase
	end

	assign reserved = (op == RESERVED);

endmodule

//--- design/signalDecode.sv
module signalDecode import mipsPkg::*; (
	input fetchDataT dataF,
	output decodeDataT dataD
);

	opT op;
	ctlT ctl;
	regAddrT srcRegA;
	regAddrT srcRegB;
	regAddrT destReg;
	logic reserved;
	logic [15:0] imm;
	wordT signImm;
	wordT zeroImm;
	wordT extendedImm;
	wordT pcBranch;
	wordT pcJump;

	mainDecode mainDecode (
		.instr(dataF.instr),
		.op(op),
		.ctl(ctl),
		.srcRegA(srcRegA),
		.srcRegB(srcRegB),
		.destReg(destReg),
		.reserved(reserved)
	);

	assign imm = dataF.instr[15:0];
	assign signImm = {{16{imm[15]}}, imm};
	assign zeroImm = {16'b0, imm};

	// lui puts the immediate in the upper half
	always_comb begin
		if (op == LUI) begin
			extendedImm = {imm, 16'b0};
		end else if (ctl.zeroExt) begin
			extendedImm = zeroImm;
		end else begin
			extendedImm = signImm;
		end
	end

	// branch offset counts words, always signed
	assign pcBranch = dataF.pcPlus4 + {signImm[29:0], 2'b00};
	// jump stays inside the current 256MB region
	assign pcJump = {dataF.pcPlus4[31:28], dataF.instr[25:0], 2'b00};

	always_comb begin
		dataD.op = op;
		dataD.ctl = ctl;
		dataD.srcRegA = srcRegA;
		dataD.srcRegB = srcRegB;
		dataD.destReg = destReg;
		dataD.shamt = dataF.instr[10:6];
		dataD.extendedImm = extendedImm;
		dataD.pcBranch = pcBranch;
		dataD.pcJump = pcJump;
		dataD.pcPlus4 = dataF.pcPlus4;
		dataD.exceptionRi = reserved;
		dataD.exceptionInstr = dataF.exceptionInstr;
	end

endmodule

//--- design/regFile.sv
`include "decode_settings.svh"

module regFile import mipsPkg::*; (
	input logic clk,
	input logic reset,
	input regWriteT regWrite,
	input regAddrT addrA,
	input regAddrT addrB,
	output wordT dataA,
	output wordT dataB
);

	wordT regs [`REG_COUNT];
	logic hitA;
	logic hitB;

	// r0 is never written
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite.en && regWrite.addr != '0) begin
			regs[regWrite.addr] <= regWrite.data;
		end
	end

	// same cycle write seen by the reads
	assign hitA = regWrite.en && (regWrite.addr == addrA);
	assign hitB = regWrite.en && (regWrite.addr == addrB);

	// zero check first, so a write to r0 never leaks through the bypass
	assign dataA = (addrA == '0) ? '0 : (hitA ? regWrite.data : regs[addrA]);
	assign dataB = (addrB == '0) ? '0 : (hitB ? regWrite.data : regs[addrB]);

endmodule

//--- design/decodeStage.sv
module decodeStage import mipsPkg::*; (
	input logic clk,
	input logic reset,
	input logic inValid,
	input fetchDataT inData,
	output logic inReady,
	input regWriteT regWrite,
	output logic outValid,
	output issueDataT outData,
	input logic outReady
);

	// IF/ID side
	logic decValid;
	logic decReady;
	fetchDataT dataF;

	// decode and operands
	decodeDataT dataD;
	wordT srcA;
	wordT srcB;
	issueDataT issue;

	pipeReg #(
		.payloadT(fetchDataT)
	) ifIdReg (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.inReady(inReady),
		.outValid(decValid),
		.outData(dataF),
		.outReady(decReady)
	);

	signalDecode decode (
		.dataF(dataF),
		.dataD(dataD)
	);

	// read while IF/ID holds the bundle
	regFile regs (
		.clk(clk),
		.reset(reset),
		.regWrite(regWrite),
		.addrA(dataD.srcRegA),
		.addrB(dataD.srcRegB),
		.dataA(srcA),
		.dataB(srcB)
	);

	assign issue = '{decoded: dataD, srcA: srcA, srcB: srcB};

	// operands are captured here on the ID/EX transfer
	pipeReg #(
		.payloadT(issueDataT)
	) idExReg (
		.clk(clk),
		.reset(reset),
		.inValid(decValid),
		.inData(issue),
		.inReady(decReady),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady)
	);

endmodule

//--- test/decodeStageTb.sv
`include "decode_settings.svh"

module decodeStageTb import mipsPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int numDirected = 31;
	localparam int numRandom = 64;
	localparam int numRewrites = 4;
	// reset, preload, rewrites, three groups with back-pressure counted twice, drains
	localparam int testCycles = 2 + (`REG_COUNT - 1) + numRewrites
		+ 2 * (2 * numDirected + numRandom) + 12;

	logic clk;
	logic reset;
	logic inValid;
	fetchDataT inData;
	logic inReady;
	regWriteT regWrite;
	logic outValid;
	issueDataT outData;
	logic outReady;

	// copy of the register file contents
	wordT shadow [`REG_COUNT];
	wordT directed [numDirected];
	issueDataT expQ [$];
	issueDataT expected;
	int seed;
	int errors;
	int checks;
	int sentCount;
	int recvCount;
	logic throttle;
	wordT readyRoll;
	wordT randomWord;

	decodeStage UUT (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.inReady(inReady),
		.regWrite(regWrite),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady)
	);

	always #5 clk = ~clk;

	function automatic wordT encodeR(regAddrT rs, regAddrT rt, regAddrT rd,
		logic [4:0] sh, logic [5:0] fn);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic wordT encodeI(logic [5:0] opc, regAddrT rs, regAddrT rt,
		logic [15:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic wordT encodeJ(logic [5:0] opc, logic [25:0] index);
		return {opc, index};
	endfunction

	// expected ID/EX payload, straight from the MIPS32 encodings
	function automatic issueDataT decodeRef(input fetchDataT f);
		issueDataT e;
		logic [5:0] opc;
		logic [5:0] fn;
		logic [15:0] imm;
		wordT sext;
		regAddrT rs;
		regAddrT rt;
		logic rAlu;
		logic iWrite;
		opc = f.instr[31:26];
		fn = f.instr[5:0];
		imm = f.instr[15:0];
		rs = f.instr[25:21];
		rt = f.instr[20:16];
		sext = {{16{imm[15]}}, imm};
		e = '0;
		e.decoded.op = RESERVED;
		if (opc == 6'h00) begin
			case (fn)
				6'h00: e.decoded.op = SLL;
				6'h02: e.decoded.op = SRL;
				6'h03: e.decoded.op = SRA;
				6'h08: e.decoded.op = JR;
				6'h21: e.decoded.op = ADDU;
				6'h23: e.decoded.op = SUBU;
				6'h24: e.decoded.op = AND;
				6'h25: e.decoded.op = OR;
				6'h26: e.decoded.op = XOR;
				6'h27: e.decoded.op = NOR;
				6'h2a: e.decoded.op = SLT;
				6'h2b: e.decoded.op = SLTU;
				default: e.decoded.op = RESERVED;
			endcase
		end else begin
			case (opc)
				6'h02: e.decoded.op = J;
				6'h03: e.decoded.op = JAL;
				6'h04: e.decoded.op = BEQ;
				6'h05: e.decoded.op = BNE;
				6'h09: e.decoded.op = ADDIU;
				6'h0a: e.decoded.op = SLTI;
				6'h0b: e.decoded.op = SLTIU;
				6'h0c: e.decoded.op = ANDI;
				6'h0d: e.decoded.op = ORI;
				6'h0e: e.decoded.op = XORI;
				6'h0f: e.decoded.op = LUI;
				6'h23: e.decoded.op = LW;
				6'h2b: e.decoded.op = SW;
				default: e.decoded.op = RESERVED;
			endcase
		end
		rAlu = e.decoded.op inside {ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA};
		iWrite = e.decoded.op inside {ADDIU, ANDI, ORI, XORI, LUI, SLTI, SLTIU, LW};
		// control bits as sets of operations
		e.decoded.ctl.regWrite = rAlu || iWrite || (e.decoded.op == JAL);
		e.decoded.ctl.memRead = (e.decoded.op == LW);
		e.decoded.ctl.memWrite = (e.decoded.op == SW);
		e.decoded.ctl.aluSrcImm = iWrite || (e.decoded.op == SW);
		e.decoded.ctl.zeroExt = e.decoded.op inside {ANDI, ORI, XORI};
		e.decoded.ctl.branch = e.decoded.op inside {BEQ, BNE};
		e.decoded.ctl.jump = e.decoded.op inside {J, JAL, JR};
		e.decoded.ctl.jumpReg = (e.decoded.op == JR);
		e.decoded.ctl.link = (e.decoded.op == JAL);
		if (rAlu) begin
			e.decoded.destReg = f.instr[15:11];
		end else if (iWrite) begin
			e.decoded.destReg = rt;
		end else if (e.decoded.op == JAL) begin
			e.decoded.destReg = 5'd31;
		end
		e.decoded.srcRegA = rs;
		e.decoded.srcRegB = rt;
		e.decoded.shamt = f.instr[10:6];
		if (e.decoded.op == LUI) begin
			e.decoded.extendedImm = {imm, 16'h0000};
		end else if (e.decoded.ctl.zeroExt) begin
			e.decoded.extendedImm = {16'h0000, imm};
		end else begin
			e.decoded.extendedImm = sext;
		end
		e.decoded.pcBranch = f.pcPlus4 + (sext << 2);
		e.decoded.pcJump = {f.pcPlus4[31:28], f.instr[25:0], 2'b00};
		e.decoded.pcPlus4 = f.pcPlus4;
		e.decoded.exceptionRi = (e.decoded.op == RESERVED);
		e.decoded.exceptionInstr = f.exceptionInstr;
		// r0 is never written in the shadow
		e.srcA = shadow[rs];
		e.srcB = shadow[rt];
		return e;
	endfunction

	task automatic compareField(input string name, input wordT got, input wordT exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic writeReg(input regAddrT addr, input wordT data);
		regWrite.en = 1'b1;
		regWrite.addr = addr;
		regWrite.data = data;
		@(posedge clk);
		#1;
		regWrite.en = 1'b0;
		if (addr != '0) begin
			shadow[addr] = data;
		end
	endtask

	// one bundle with a random pc and a rare fetch fault
	task automatic sendBundle(input wordT instr);
		fetchDataT f;
		wordT pcRoll;
		wordT faultRoll;
		pcRoll = $random(seed);
		faultRoll = $random(seed);
		f.pcPlus4 = {pcRoll[31:2], 2'b00};
		f.instr = instr;
		f.exceptionInstr = (faultRoll[2:0] == 3'b000);
		expQ.push_back(decodeRef(f));
		inData = f;
		inValid = 1'b1;
		@(posedge clk);
		while (!inReady) begin
			@(posedge clk);
		end
		sentCount++;
		#1;
		inValid = 1'b0;
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		#1;
	endtask

	task automatic buildProgram();
		directed[0] = encodeR(5'd1, 5'd2, 5'd3, 5'd0, 6'h21);
		directed[1] = encodeR(5'd4, 5'd5, 5'd6, 5'd0, 6'h23);
		directed[2] = encodeR(5'd7, 5'd8, 5'd9, 5'd0, 6'h24);
		directed[3] = encodeR(5'd10, 5'd11, 5'd12, 5'd0, 6'h25);
		directed[4] = encodeR(5'd13, 5'd14, 5'd15, 5'd0, 6'h26);
		directed[5] = encodeR(5'd16, 5'd17, 5'd18, 5'd0, 6'h27);
		directed[6] = encodeR(5'd19, 5'd20, 5'd21, 5'd0, 6'h2a);
		directed[7] = encodeR(5'd22, 5'd23, 5'd24, 5'd0, 6'h2b);
		// shifts use shamt and rt
		directed[8] = encodeR(5'd0, 5'd25, 5'd26, 5'd7, 6'h00);
		directed[9] = encodeR(5'd0, 5'd27, 5'd28, 5'd31, 6'h02);
		directed[10] = encodeR(5'd0, 5'd29, 5'd30, 5'd1, 6'h03);
		directed[11] = encodeR(5'd31, 5'd0, 5'd0, 5'd0, 6'h08);
		directed[12] = encodeI(6'h09, 5'd1, 5'd2, 16'hfff0);
		directed[13] = encodeI(6'h0c, 5'd3, 5'd4, 16'h8001);
		directed[14] = encodeI(6'h0d, 5'd5, 5'd6, 16'hf00f);
		directed[15] = encodeI(6'h0e, 5'd7, 5'd8, 16'h1234);
		directed[16] = encodeI(6'h0f, 5'd0, 5'd9, 16'hbeef);
		directed[17] = encodeI(6'h0a, 5'd10, 5'd11, 16'h8000);
		directed[18] = encodeI(6'h0b, 5'd12, 5'd13, 16'h7fff);
		directed[19] = encodeI(6'h23, 5'd14, 5'd15, 16'hfffc);
		directed[20] = encodeI(6'h2b, 5'd16, 5'd17, 16'h0010);
		directed[21] = encodeI(6'h04, 5'd18, 5'd19, 16'hffff);
		directed[22] = encodeI(6'h05, 5'd20, 5'd21, 16'h0040);
		directed[23] = encodeJ(6'h02, 26'h3ff_ffff);
		directed[24] = encodeJ(6'h03, 26'h012_3456);
		// r0 as a source
		directed[25] = encodeR(5'd0, 5'd0, 5'd5, 5'd0, 6'h21);
		directed[26] = encodeI(6'h0d, 5'd0, 5'd6, 16'h00ff);
		// reserved: all ones, SYSCALL, ADDI, LB
		directed[27] = 32'hffff_ffff;
		directed[28] = encodeR(5'd0, 5'd0, 5'd0, 5'd0, 6'h0c);
		directed[29] = encodeI(6'h08, 5'd1, 5'd2, 16'h0005);
		directed[30] = encodeI(6'h20, 5'd3, 5'd4, 16'h0008);
	endtask

	// compare at each output transfer
	always @(posedge clk) begin
		if (!reset && outValid && outReady) begin
			recvCount++;
			if (expQ.size() == 0) begin
				errors++;
				$display("ERROR %0t ns: output bundle with nothing outstanding", $time);
			end else begin
				expected = expQ.pop_front();
				compareField("op", 32'(outData.decoded.op), 32'(expected.decoded.op));
				compareField("ctl", 32'(outData.decoded.ctl), 32'(expected.decoded.ctl));
				compareField("srcRegA", 32'(outData.decoded.srcRegA),
					32'(expected.decoded.srcRegA));
				compareField("srcRegB", 32'(outData.decoded.srcRegB),
					32'(expected.decoded.srcRegB));
				compareField("destReg", 32'(outData.decoded.destReg),
					32'(expected.decoded.destReg));
				compareField("shamt", 32'(outData.decoded.shamt), 32'(expected.decoded.shamt));
				compareField("extendedImm", outData.decoded.extendedImm,
					expected.decoded.extendedImm);
				compareField("pcBranch", outData.decoded.pcBranch, expected.decoded.pcBranch);
				compareField("pcJump", outData.decoded.pcJump, expected.decoded.pcJump);
				compareField("pcPlus4", outData.decoded.pcPlus4, expected.decoded.pcPlus4);
				compareField("exceptionRi", 32'(outData.decoded.exceptionRi),
					32'(expected.decoded.exceptionRi));
				compareField("exceptionInstr", 32'(outData.decoded.exceptionInstr),
					32'(expected.decoded.exceptionInstr));
				compareField("srcA", outData.srcA, expected.srcA);
				compareField("srcB", outData.srcB, expected.srcB);
			end
		end
	end

	// random back-pressure once throttle is on
	always @(posedge clk) begin
		#1;
		if (throttle) begin
			readyRoll = $random(seed);
			outReady = readyRoll[0];
		end else begin
			outReady = 1'b1;
		end
	end

	initial begin
		#((20 * testCycles + 100) * 10);
		$display("timeout: run did not finish within %0d cycles", 20 * testCycles + 100);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		regWrite = '0;
		outReady = 1'b1;
		throttle = 1'b0;
		seed = 32'h1e5f_c04e;
		errors = 0;
		checks = 0;
		sentCount = 0;
		recvCount = 0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			shadow[i] = '0;
		end
		buildProgram();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		checks++;
		if (outValid !== 1'b0 || inReady !== 1'b1) begin
			errors++;
			$display("ERROR %0t ns: after reset outValid %b inReady %b", $time, outValid, inReady);
		end
		// preload r1..r31
		for (int i = 1; i < `REG_COUNT; i++) begin
			randomWord = $random(seed);
			writeReg(regAddrT'(i), randomWord);
		end
		foreach (directed[i]) begin
			sendBundle(directed[i]);
		end
		waitDrain();
		// r0 write must stay invisible
		writeReg(5'd0, 32'hdead_beef);
		randomWord = $random(seed);
		writeReg(5'd5, randomWord);
		randomWord = $random(seed);
		writeReg(5'd17, randomWord);
		randomWord = $random(seed);
		writeReg(5'd31, randomWord);
		throttle = 1'b1;
		foreach (directed[i]) begin
			sendBundle(directed[i]);
		end
		for (int i = 0; i < numRandom; i++) begin
			randomWord = $random(seed);
			sendBundle(randomWord);
		end
		waitDrain();
		// idle a few cycles so a stray extra bundle would show up
		throttle = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		checks++;
		if (recvCount != sentCount || outValid !== 1'b0) begin
			errors++;
			$display("ERROR %0t ns: %0d bundles out, %0d in, outValid %b", $time,
				recvCount, sentCount, outValid);
		end
		$display("errors %0d, checks %0d, sent %0d, received %0d",
			errors, checks, sentCount, recvCount);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+design
design/mipsPkg.sv
design/pipeReg.sv
design/mainDecode.sv
design/signalDecode.sv
design/regFile.sv
design/decodeStage.sv
test/decodeStageTb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --timescale 1ns/1ps -f files.f \
		--top-module decodeStageTb -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/VdecodeStageTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST RESULT: PASS$$"

clean:
	rm -rf obj_dir
